/* axis_handshake_rules.sv */
/*
  AXI4-Stream handshake rules: tvalid after reset, payload stability
  while a beat is stalled, and tstrb only inside tkeep
*/

`timescale 1ns/1ps

`include "axis_mon_defs.svh"

module axis_handshake_rules (
  input  logic                          aclk,
  input  logic                          rst,
  input  logic [`AXIS_DATA_WIDTH-1:0]   tdata,
  input  logic [`AXIS_DATA_BYTES-1:0]   tstrb,
  input  logic [`AXIS_DATA_BYTES-1:0]   tkeep,
  input  logic                          tlast,
  input  logic [`AXIS_ID_WIDTH-1:0]     tid,
  input  logic [`AXIS_DEST_WIDTH-1:0]   tdest,
  input  logic [`AXIS_USER_WIDTH-1:0]   tuser,
  input  logic                          tvalid,
  input  logic                          tready,
  output axis_mon_pkg::hit_vec_t        hits
);

  // Control history
  logic                          in_reset_q;
  logic                          stalled_q;

  // Copy of the previous cycle's beat
  logic [`AXIS_DATA_WIDTH-1:0]   tdata_q;
  logic [`AXIS_DATA_BYTES-1:0]   tstrb_q;
  logic [`AXIS_DATA_BYTES-1:0]   tkeep_q;
  logic                          tlast_q;
  logic [`AXIS_ID_WIDTH-1:0]     tid_q;
  logic [`AXIS_DEST_WIDTH-1:0]   tdest_q;
  logic [`AXIS_USER_WIDTH-1:0]   tuser_q;

  logic [`AXIS_DATA_WIDTH-1:0]   data_mask;
  logic                          stable_check;
  logic                          first_live;

  // ------------------------------------------------
  // History registers
  // ------------------------------------------------

  // in_reset_q marks the first cycle after rst falls
  always_ff @(posedge aclk)
  begin
    if (rst)
    begin
      in_reset_q <= 1'b1;
      stalled_q  <= 1'b0;
    end
    else
    begin
      in_reset_q <= 1'b0;
      stalled_q  <= tvalid & ~tready;
    end
  end

  // Beat copy refreshed every cycle
  always_ff @(posedge aclk)
  begin
    tdata_q <= tdata;
    tstrb_q <= tstrb;
    tkeep_q <= tkeep;
    tlast_q <= tlast;
    tid_q   <= tid;
    tdest_q <= tdest;
    tuser_q <= tuser;
  end

  // ------------------------------------------------
  // Rule evaluation
  // ------------------------------------------------

  // Only strobed bytes of the held beat must stay put
  always_comb
  begin
    for (int i = 0; i < `AXIS_DATA_BYTES; i++)
      data_mask[i*8 +: 8] = {8{tstrb_q[i]}};
  end

  // Previous cycle stalled and rules apply only outside reset
  assign stable_check = stalled_q & ~rst;
  assign first_live   = in_reset_q & ~rst;

  always_comb
  begin
    hits = '0;
    hits[axis_mon_pkg::VIOL_TVALID_RESET] = first_live & tvalid;
    hits[axis_mon_pkg::VIOL_TVALID_DROP]  = stable_check & ~tvalid;
    hits[axis_mon_pkg::VIOL_TDATA_CHANGE] =
      stable_check & ((tdata & data_mask) != (tdata_q & data_mask));
    hits[axis_mon_pkg::VIOL_TSTRB_CHANGE] = stable_check & (tstrb != tstrb_q);
    hits[axis_mon_pkg::VIOL_TKEEP_CHANGE] = stable_check & (tkeep != tkeep_q);
    hits[axis_mon_pkg::VIOL_TLAST_CHANGE] = stable_check & (tlast != tlast_q);
    hits[axis_mon_pkg::VIOL_TID_CHANGE]   = stable_check & (tid != tid_q);
    hits[axis_mon_pkg::VIOL_TDEST_CHANGE] = stable_check & (tdest != tdest_q);
    hits[axis_mon_pkg::VIOL_TUSER_CHANGE] = stable_check & (tuser != tuser_q);
    // Null bytes must not carry a strobe
    hits[axis_mon_pkg::VIOL_KEEP_STRB]    = ~rst & tvalid & (|(tstrb & ~tkeep));
  end

  // Reset rule only in the first live cycle after rst
  a_reset_rule_timing: assert property (@(posedge aclk)
    hits[axis_mon_pkg::VIOL_TVALID_RESET] |-> !rst && $past(rst));

  // Stability hits only follow a stalled beat seen outside reset
  a_stall_rule_timing: assert property (@(posedge aclk)
    (|hits[axis_mon_pkg::VIOL_TUSER_CHANGE:axis_mon_pkg::VIOL_TVALID_DROP]) |->
      !rst && $past(tvalid && !tready && !rst));

endmodule

/* axis_mon_defs.svh */
/*
  AXI4-Stream protocol monitor: widths and limits of the watched stream
*/

`ifndef AXIS_MON_DEFS_SVH
`define AXIS_MON_DEFS_SVH

// ------------------------------------------------
// Stream widths
// ------------------------------------------------

// Bytes per beat, one tstrb/tkeep bit each
`define AXIS_DATA_BYTES 4
// Full data bus width
`define AXIS_DATA_WIDTH (`AXIS_DATA_BYTES * 8)
// Stream id, kept small so the tracker table stays tiny
`define AXIS_ID_WIDTH 2
// Routing field, 4 id x 4 dest = 16 tracked streams
`define AXIS_DEST_WIDTH 2
// Sideband user bits
`define AXIS_USER_WIDTH 8

// ------------------------------------------------
// Limits
// ------------------------------------------------

// Waits allowed after the first stalled cycle
`define AXIS_MAX_WAITS 16
// Saturating violation counter
`define AXIS_COUNT_WIDTH 8

`endif

/* axis_mon_pkg.sv */
/*
  AXI4-Stream protocol monitor types: rule codes, per-cycle hit vector
  and the stall watchdog states
*/

package axis_mon_pkg;

  // ------------------------------------------------
  // Rule codes
  // ------------------------------------------------

  // Lower code wins when several rules fail together
  typedef enum logic [3:0] {
    VIOL_NONE          = 4'd0,
    VIOL_TVALID_RESET  = 4'd1,
    VIOL_TVALID_DROP   = 4'd2,
    VIOL_TDATA_CHANGE  = 4'd3,
    VIOL_TSTRB_CHANGE  = 4'd4,
    VIOL_TKEEP_CHANGE  = 4'd5,
    VIOL_TLAST_CHANGE  = 4'd6,
    VIOL_TID_CHANGE    = 4'd7,
    VIOL_TDEST_CHANGE  = 4'd8,
    VIOL_TUSER_CHANGE  = 4'd9,
    VIOL_KEEP_STRB     = 4'd10,
    VIOL_STALL_TIMEOUT = 4'd11,
    VIOL_OPEN_AT_EOS   = 4'd12
  } violation_e;

  // One bit per code, bit 0 (VIOL_NONE) never set
  localparam int NUM_RULES = 13;
  typedef logic [NUM_RULES-1:0] hit_vec_t;

  // ------------------------------------------------
  // Stall watchdog
  // ------------------------------------------------
  typedef enum logic [1:0] {
    STALL_IDLE    = 2'd0,
    STALL_WAIT    = 2'd1,
    STALL_FLAGGED = 2'd2
  } stall_state_e;

endpackage

/* axis_protocol_monitor.sv */
/*
  AXI4-Stream protocol monitor top: three independent checkers feed one
  violation log, results seen one cycle after the offending beat
*/

`timescale 1ns/1ps

`include "axis_mon_defs.svh"

module axis_protocol_monitor (
  input  logic                           aclk,
  input  logic                           rst,
  // Watched stream, observed only
  input  logic [`AXIS_DATA_WIDTH-1:0]    tdata,
  input  logic [`AXIS_DATA_BYTES-1:0]    tstrb,
  input  logic [`AXIS_DATA_BYTES-1:0]    tkeep,
  input  logic                           tlast,
  input  logic [`AXIS_ID_WIDTH-1:0]      tid,
  input  logic [`AXIS_DEST_WIDTH-1:0]    tdest,
  input  logic [`AXIS_USER_WIDTH-1:0]    tuser,
  input  logic                           tvalid,
  input  logic                           tready,
  // Control
  input  logic                           eos,
  input  logic                           log_clear,
  // Results
  output logic                           error,
  output axis_mon_pkg::violation_e       first_rule,
  output logic [`AXIS_COUNT_WIDTH-1:0]   violation_count,
  output logic                           streams_open
);

  // Each checker owns a disjoint set of bits
  axis_mon_pkg::hit_vec_t hits_hs;
  axis_mon_pkg::hit_vec_t hits_wd;
  axis_mon_pkg::hit_vec_t hits_tr;
  axis_mon_pkg::hit_vec_t hits_all;

  axis_handshake_rules u_handshake (
    .aclk   (aclk),
    .rst    (rst),
    .tdata  (tdata),
    .tstrb  (tstrb),
    .tkeep  (tkeep),
    .tlast  (tlast),
    .tid    (tid),
    .tdest  (tdest),
    .tuser  (tuser),
    .tvalid (tvalid),
    .tready (tready),
    .hits   (hits_hs)
  );

  axis_stall_watchdog u_watchdog (
    .aclk   (aclk),
    .rst    (rst),
    .tvalid (tvalid),
    .tready (tready),
    .hits   (hits_wd)
  );

  axis_stream_tracker u_tracker (
    .aclk         (aclk),
    .rst          (rst),
    .tid          (tid),
    .tdest        (tdest),
    .tlast        (tlast),
    .tvalid       (tvalid),
    .tready       (tready),
    .eos          (eos),
    .hits         (hits_tr),
    .streams_open (streams_open)
  );

  // Merge for the log
  assign hits_all = hits_hs | hits_wd | hits_tr;

  axis_violation_log u_log (
    .aclk            (aclk),
    .rst             (rst),
    .log_clear       (log_clear),
    .hits            (hits_all),
    .error           (error),
    .first_rule      (first_rule),
    .violation_count (violation_count)
  );

endmodule

/* axis_stall_watchdog.sv */
/*
  Stall watchdog: counts consecutive tvalid-without-tready cycles and
  flags one timeout per over-long stall
*/

`timescale 1ns/1ps

`include "axis_mon_defs.svh"

module axis_stall_watchdog (
  input  logic                    aclk,
  input  logic                    rst,
  input  logic                    tvalid,
  input  logic                    tready,
  output axis_mon_pkg::hit_vec_t  hits
);

  // First stalled cycle plus the allowed waits
  localparam int WAIT_LIMIT = `AXIS_MAX_WAITS + 1;
  localparam int CNT_WIDTH  = $clog2(WAIT_LIMIT + 1);

  axis_mon_pkg::stall_state_e state;
  axis_mon_pkg::stall_state_e state_next;
  logic [CNT_WIDTH-1:0]       wait_cnt;
  logic [CNT_WIDTH-1:0]       wait_cnt_next;
  logic                       stalled;
  logic                       limit_hit;

  assign stalled = tvalid & ~tready;

  // wait_cnt holds the stalled cycles already seen in this episode
  assign limit_hit = (state == axis_mon_pkg::STALL_WAIT) && stalled &&
                     (wait_cnt == CNT_WIDTH'(WAIT_LIMIT));

  // ------------------------------------------------
  // Episode FSM
  // ------------------------------------------------
  always_comb
  begin
    state_next    = state;
    wait_cnt_next = wait_cnt;
    unique case (state)
      axis_mon_pkg::STALL_IDLE:
        if (stalled)
        begin
          state_next    = axis_mon_pkg::STALL_WAIT;
          wait_cnt_next = CNT_WIDTH'(1);
        end
      axis_mon_pkg::STALL_WAIT:
        if (!stalled)
        begin
          state_next    = axis_mon_pkg::STALL_IDLE;
          wait_cnt_next = '0;
        end
        else if (limit_hit)
          state_next = axis_mon_pkg::STALL_FLAGGED;
        else
          wait_cnt_next = wait_cnt + 1'b1;
      // Flagged once, silent until the stall ends
      axis_mon_pkg::STALL_FLAGGED:
        if (!stalled)
        begin
          state_next    = axis_mon_pkg::STALL_IDLE;
          wait_cnt_next = '0;
        end
      default:
      begin
        state_next    = axis_mon_pkg::STALL_IDLE;
        wait_cnt_next = '0;
      end
    endcase
  end

  always_ff @(posedge aclk)
  begin
    if (rst)
    begin
      state    <= axis_mon_pkg::STALL_IDLE;
      wait_cnt <= '0;
    end
    else
    begin
      state    <= state_next;
      wait_cnt <= wait_cnt_next;
    end
  end

  // Timeout only on the step into flagged
  always_comb
  begin
    hits = '0;
    hits[axis_mon_pkg::VIOL_STALL_TIMEOUT] = limit_hit;
  end

  // Counter parks at the limit once flagged
  a_cnt_bounded: assert property (@(posedge aclk) disable iff (rst)
    wait_cnt <= CNT_WIDTH'(WAIT_LIMIT));

endmodule

/* axis_stream_tracker.sv */
/*
  Stream tracker: one in-use bit per (tid, tdest) pair, checked for
  open packets when end-of-simulation rises
*/

`timescale 1ns/1ps

`include "axis_mon_defs.svh"

module axis_stream_tracker (
  input  logic                          aclk,
  input  logic                          rst,
  input  logic [`AXIS_ID_WIDTH-1:0]     tid,
  input  logic [`AXIS_DEST_WIDTH-1:0]   tdest,
  input  logic                          tlast,
  input  logic                          tvalid,
  input  logic                          tready,
  input  logic                          eos,
  output axis_mon_pkg::hit_vec_t        hits,
  output logic                          streams_open
);

  localparam int IDX_WIDTH = `AXIS_ID_WIDTH + `AXIS_DEST_WIDTH;

  // One bit per stream, set while a packet is in flight
  logic [2**IDX_WIDTH-1:0]  in_use;
  logic [IDX_WIDTH-1:0]     stream_idx;
  logic                     eos_q;
  logic                     eos_rise;

  // tid in the upper bits, tdest below
  assign stream_idx = {tid, tdest};
  assign eos_rise   = eos & ~eos_q;

  // ------------------------------------------------
  // In-use table
  // ------------------------------------------------

  // Any valid cycle opens the stream; only an accepted tlast closes it
  always_ff @(posedge aclk)
  begin
    if (rst)
    begin
      in_use       <= '0;
      eos_q        <= 1'b0;
      streams_open <= 1'b0;
    end
    else
    begin
      eos_q        <= eos;
      // Table summary, one cycle behind the table
      streams_open <= |in_use;
      if (tvalid)
        in_use[stream_idx] <= ~(tlast & tready);
    end
  end

  // ------------------------------------------------
  // End-of-simulation check
  // ------------------------------------------------
  always_comb
  begin
    hits = '0;
    hits[axis_mon_pkg::VIOL_OPEN_AT_EOS] = eos_rise & (|in_use);
  end

  // eos is a one-way level until the next reset
  a_eos_sticky: assert property (@(posedge aclk) disable iff (rst)
    eos_q |-> eos);

endmodule

/* axis_violation_log.sv */
/*
  Violation log: sticky error flag, first rule broken and a saturating
  count of cycles with any hit
*/

`timescale 1ns/1ps

`include "axis_mon_defs.svh"

module axis_violation_log (
  input  logic                           aclk,
  input  logic                           rst,
  input  logic                           log_clear,
  input  axis_mon_pkg::hit_vec_t         hits,
  output logic                           error,
  output axis_mon_pkg::violation_e       first_rule,
  output logic [`AXIS_COUNT_WIDTH-1:0]   violation_count
);

  axis_mon_pkg::violation_e top_rule;
  logic                     any_hit;
  logic                     count_full;

  // ------------------------------------------------
  // Priority pick
  // ------------------------------------------------

  // Walk down so the lowest set code is the last one written
  always_comb
  begin
    top_rule = axis_mon_pkg::VIOL_NONE;
    for (int i = axis_mon_pkg::NUM_RULES - 1; i > 0; i--)
      if (hits[i])
        top_rule = axis_mon_pkg::violation_e'(4'(i));
  end

  assign any_hit    = |hits;
  assign count_full = &violation_count;

  // ------------------------------------------------
  // Sticky record
  // ------------------------------------------------

  // Clear wins over hits in the same cycle
  always_ff @(posedge aclk)
  begin
    if (rst || log_clear)
    begin
      error           <= 1'b0;
      first_rule      <= axis_mon_pkg::VIOL_NONE;
      violation_count <= '0;
    end
    else if (any_hit)
    begin
      error <= 1'b1;
      // First code is frozen until clear
      if (!error)
        first_rule <= top_rule;
      // One per cycle, not per bit
      if (!count_full)
        violation_count <= violation_count + 1'b1;
    end
  end

  // Record and flag always move together
  a_rule_matches_error: assert property (@(posedge aclk) disable iff (rst)
    (first_rule == axis_mon_pkg::VIOL_NONE) == !error);

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the AXI4-Stream monitor testbench with Verilator and run it.
# The run passes only when the pass line shows up in the output.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_axis_protocol_monitor -f verilog.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -qF "ALL CHECKS PASSED" &&
echo "run.sh: simulation passed" ||
{
  echo "run.sh: simulation failed"
  exit 1
}

/* tb_axis_protocol_monitor.sv */
/*
  Testbench for the AXI4-Stream protocol monitor: a table of stream cycles
  with the expected log state, applied in a loop and checked one cycle later
*/

`timescale 1ns/1ps

`include "axis_mon_defs.svh"

module tb_axis_protocol_monitor;

  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYCLES = 16;
  localparam logic [31:0] LFSR_SEED = 32'h00f1_19e1;

  // Payload edits applied on top of the held beat
  localparam int CHG_NONE = 0;
  localparam int CHG_DATA = 1;
  localparam int CHG_USER = 2;

  // One table row per group of identical cycles
  // exp_open of -1 skips the streams_open check
  typedef struct {
    string                       name;
    int                          reps;
    int                          rst;
    int                          valid;
    int                          ready;
    logic [`AXIS_DATA_BYTES-1:0] strb;
    logic [`AXIS_DATA_BYTES-1:0] keep;
    int                          last;
    int                          id;
    int                          dest;
    int                          chg;
    int                          eos;
    int                          clr;
    int                          exp_err;
    axis_mon_pkg::violation_e    exp_rule;
    int                          exp_cnt;
    int                          exp_open;
  } row_t;

  logic                          aclk;
  logic                          rst;
  logic [`AXIS_DATA_WIDTH-1:0]   tdata;
  logic [`AXIS_DATA_BYTES-1:0]   tstrb;
  logic [`AXIS_DATA_BYTES-1:0]   tkeep;
  logic                          tlast;
  logic [`AXIS_ID_WIDTH-1:0]     tid;
  logic [`AXIS_DEST_WIDTH-1:0]   tdest;
  logic [`AXIS_USER_WIDTH-1:0]   tuser;
  logic                          tvalid;
  logic                          tready;
  logic                          eos;
  logic                          log_clear;
  logic                          error;
  axis_mon_pkg::violation_e      first_rule;
  logic [`AXIS_COUNT_WIDTH-1:0]  violation_count;
  logic                          streams_open;

  row_t                          rows[$];
  logic [31:0]                   lfsr_state;
  logic [`AXIS_DATA_WIDTH-1:0]   cur_data;
  logic [`AXIS_USER_WIDTH-1:0]   cur_user;
  logic                          prev_stalled;

  axis_protocol_monitor dut (
    .aclk            (aclk),
    .rst             (rst),
    .tdata           (tdata),
    .tstrb           (tstrb),
    .tkeep           (tkeep),
    .tlast           (tlast),
    .tid             (tid),
    .tdest           (tdest),
    .tuser           (tuser),
    .tvalid          (tvalid),
    .tready          (tready),
    .eos             (eos),
    .log_clear       (log_clear),
    .error           (error),
    .first_rule      (first_rule),
    .violation_count (violation_count),
    .streams_open    (streams_open)
  );

  initial
  begin
    aclk = 1'b0;
    forever #(CLK_PERIOD / 2) aclk = ~aclk;
  end

  // ------------------------------------------------
  // Random payload
  // ------------------------------------------------

  // Galois form with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    else
      return s >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int b = 0; b < n; b++)
    begin
      val        = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // ------------------------------------------------
  // Failure reporting and checks
  // ------------------------------------------------
  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic compare_values(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    if (expected !== actual)
      stop_with_failure($sformatf("error: %s expected %0d actual %0d",
                                  name, expected, actual));
  endtask

  task automatic check_outputs(input row_t r, input int rep);
    string tag;
    tag = $sformatf("%s[%0d]", r.name, rep);
    compare_values({tag, " error"}, r.exp_err, 32'(error));
    compare_values({tag, " first_rule"}, 32'(r.exp_rule), 32'(first_rule));
    compare_values({tag, " count"}, r.exp_cnt, 32'(violation_count));
    if (r.exp_open >= 0)
      compare_values({tag, " streams_open"}, r.exp_open, 32'(streams_open));
  endtask

  // Bounded wait for a quiet log after reset
  task automatic wait_log_idle(input int max_cycles);
    int n;
    n = 0;
    while (error !== 1'b0 || violation_count !== '0 || streams_open !== 1'b0)
    begin
      if (n == max_cycles)
        stop_with_failure("monitor log did not come out of reset in time");
      @(negedge aclk);
      n++;
    end
  endtask

  // ------------------------------------------------
  // Stimulus table
  // ------------------------------------------------
  task automatic add_row(input string name, input int reps, input int rst_v,
                         input int valid, input int ready,
                         input logic [`AXIS_DATA_BYTES-1:0] strb,
                         input logic [`AXIS_DATA_BYTES-1:0] keep,
                         input int last, input int id, input int dest, input int chg,
                         input int eos_v, input int clr, input int exp_err,
                         input axis_mon_pkg::violation_e exp_rule,
                         input int exp_cnt, input int exp_open);
    row_t r;
    r = '{name, reps, rst_v, valid, ready, strb, keep, last, id, dest, chg,
          eos_v, clr, exp_err, exp_rule, exp_cnt, exp_open};
    rows.push_back(r);
  endtask

  task automatic build_table();
    // Clean traffic with short stalls and packets on three streams
    add_row("idle", 2, 0, 0, 1, 4'hf, 4'hf, 0, 0, 0, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 0);
    add_row("pkt a first", 1, 0, 1, 1, 4'hf, 4'hf, 0, 1, 2, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 0);
    add_row("pkt a stall", 3, 0, 1, 0, 4'hf, 4'hf, 0, 1, 2, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 1);
    add_row("pkt a accept", 1, 0, 1, 1, 4'hf, 4'hf, 0, 1, 2, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 1);
    add_row("pkt a tail", 1, 0, 1, 1, 4'hf, 4'hf, 1, 1, 2, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 1);
    add_row("pkt b", 1, 0, 1, 1, 4'hf, 4'hf, 1, 3, 0, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 0);
    add_row("pkt c stall", 5, 0, 1, 0, 4'h3, 4'h3, 1, 2, 1, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, -1);
    add_row("pkt c accept", 1, 0, 1, 1, 4'h3, 4'h3, 1, 2, 1, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 1);
    add_row("clean idle", 2, 0, 0, 1, 4'hf, 4'hf, 0, 0, 0, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 0);
    // tvalid in the first live cycle and then a dropped stall
    add_row("reset", 1, 1, 0, 1, 4'hf, 4'hf, 0, 0, 0, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 0);
    add_row("valid after reset", 1, 0, 1, 1, 4'hf, 4'hf, 1, 0, 0, CHG_NONE, 0, 0,
            1, axis_mon_pkg::VIOL_TVALID_RESET, 1, 0);
    add_row("clear", 1, 0, 0, 1, 4'hf, 4'hf, 0, 0, 0, CHG_NONE, 0, 1,
            0, axis_mon_pkg::VIOL_NONE, 0, 0);
    add_row("drop stall", 1, 0, 1, 0, 4'hf, 4'hf, 1, 0, 0, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 0);
    add_row("valid drop", 1, 0, 0, 1, 4'hf, 4'hf, 1, 0, 0, CHG_NONE, 0, 0,
            1, axis_mon_pkg::VIOL_TVALID_DROP, 1, 1);
    add_row("clear", 1, 0, 0, 1, 4'hf, 4'hf, 0, 0, 0, CHG_NONE, 0, 1,
            0, axis_mon_pkg::VIOL_NONE, 0, 1);
    add_row("close 0/0", 1, 0, 1, 1, 4'hf, 4'hf, 1, 0, 0, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 1);
    // Byte 0 edits first outside the strobe and then inside it
    add_row("strb stall", 2, 0, 1, 0, 4'he, 4'hf, 1, 0, 0, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, -1);
    add_row("unstrobed lane", 1, 0, 1, 0, 4'he, 4'hf, 1, 0, 0, CHG_DATA, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 1);
    add_row("unstrobed accept", 1, 0, 1, 1, 4'he, 4'hf, 1, 0, 0, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 1);
    add_row("data stall", 1, 0, 1, 0, 4'hf, 4'hf, 1, 0, 0, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 0);
    add_row("strobed lane", 1, 0, 1, 0, 4'hf, 4'hf, 1, 0, 0, CHG_DATA, 0, 0,
            1, axis_mon_pkg::VIOL_TDATA_CHANGE, 1, 1);
    add_row("accept and clear", 1, 0, 1, 1, 4'hf, 4'hf, 1, 0, 0, CHG_NONE, 0, 1,
            0, axis_mon_pkg::VIOL_NONE, 0, 1);
    // tdest and tuser move together and tdest wins by priority
    add_row("dest stall", 1, 0, 1, 0, 4'hf, 4'hf, 1, 1, 1, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 0);
    add_row("dest and user", 1, 0, 1, 0, 4'hf, 4'hf, 1, 1, 2, CHG_USER, 0, 0,
            1, axis_mon_pkg::VIOL_TDEST_CHANGE, 1, 1);
    add_row("dest accept", 1, 0, 1, 1, 4'hf, 4'hf, 1, 1, 2, CHG_NONE, 0, 0,
            1, axis_mon_pkg::VIOL_TDEST_CHANGE, 1, 1);
    add_row("clear", 1, 0, 0, 1, 4'hf, 4'hf, 0, 0, 0, CHG_NONE, 0, 1,
            0, axis_mon_pkg::VIOL_NONE, 0, 1);
    add_row("close 1/1", 1, 0, 1, 1, 4'hf, 4'hf, 1, 1, 1, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 1);
    // Strobe on a null byte
    add_row("keep strb", 1, 0, 1, 1, 4'h3, 4'h1, 1, 0, 0, CHG_NONE, 0, 0,
            1, axis_mon_pkg::VIOL_KEEP_STRB, 1, 0);
    add_row("clear", 1, 0, 0, 1, 4'hf, 4'hf, 0, 0, 0, CHG_NONE, 0, 1,
            0, axis_mon_pkg::VIOL_NONE, 0, 0);
    // Watchdog passes 17 stalled cycles and flags the 18th once
    add_row("stall 17", 17, 0, 1, 0, 4'hf, 4'hf, 1, 0, 3, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, -1);
    add_row("accept 17", 1, 0, 1, 1, 4'hf, 4'hf, 1, 0, 3, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 1);
    add_row("stall 18", 17, 0, 1, 0, 4'hf, 4'hf, 1, 0, 3, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, -1);
    add_row("stall 18th", 1, 0, 1, 0, 4'hf, 4'hf, 1, 0, 3, CHG_NONE, 0, 0,
            1, axis_mon_pkg::VIOL_STALL_TIMEOUT, 1, 1);
    add_row("stall long", 4, 0, 1, 0, 4'hf, 4'hf, 1, 0, 3, CHG_NONE, 0, 0,
            1, axis_mon_pkg::VIOL_STALL_TIMEOUT, 1, 1);
    add_row("long accept", 1, 0, 1, 1, 4'hf, 4'hf, 1, 0, 3, CHG_NONE, 0, 0,
            1, axis_mon_pkg::VIOL_STALL_TIMEOUT, 1, 1);
    add_row("clear", 1, 0, 0, 1, 4'hf, 4'hf, 0, 0, 0, CHG_NONE, 0, 1,
            0, axis_mon_pkg::VIOL_NONE, 0, 0);
    // End of test with one packet left open
    add_row("open pkt", 1, 0, 1, 1, 4'hf, 4'hf, 0, 2, 3, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 0);
    add_row("open idle", 1, 0, 0, 1, 4'hf, 4'hf, 0, 0, 0, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 1);
    add_row("eos open", 1, 0, 0, 1, 4'hf, 4'hf, 0, 0, 0, CHG_NONE, 1, 0,
            1, axis_mon_pkg::VIOL_OPEN_AT_EOS, 1, 1);
    add_row("eos hold", 2, 0, 0, 1, 4'hf, 4'hf, 0, 0, 0, CHG_NONE, 1, 0,
            1, axis_mon_pkg::VIOL_OPEN_AT_EOS, 1, 1);
    add_row("eos clear", 1, 0, 0, 1, 4'hf, 4'hf, 0, 0, 0, CHG_NONE, 1, 1,
            0, axis_mon_pkg::VIOL_NONE, 0, 1);
    add_row("eos reset", 1, 1, 0, 1, 4'hf, 4'hf, 0, 0, 0, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 0);
    add_row("after reset", 1, 0, 0, 1, 4'hf, 4'hf, 0, 0, 0, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 0);
    add_row("closed pkt", 1, 0, 1, 1, 4'hf, 4'hf, 1, 2, 3, CHG_NONE, 0, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 0);
    add_row("eos closed", 3, 0, 0, 1, 4'hf, 4'hf, 0, 0, 0, CHG_NONE, 1, 0,
            0, axis_mon_pkg::VIOL_NONE, 0, 0);
  endtask

  // ------------------------------------------------
  // Driving
  // ------------------------------------------------

  // Fresh payload unless the previous beat is still stalled
  task automatic drive_inputs(input row_t r);
    logic [31:0] bits;
    if (!prev_stalled)
    begin
      take_bits(`AXIS_DATA_WIDTH, bits);
      cur_data = bits;
      take_bits(`AXIS_USER_WIDTH, bits);
      cur_user = bits[`AXIS_USER_WIDTH-1:0];
    end
    if (r.chg == CHG_DATA)
      cur_data = cur_data ^ 32'h0000_00ff;
    if (r.chg == CHG_USER)
      cur_user = cur_user ^ 8'h5a;
    prev_stalled = (r.valid != 0) && (r.ready == 0) && (r.rst == 0);
    rst       <= (r.rst != 0);
    tvalid    <= (r.valid != 0);
    tready    <= (r.ready != 0);
    tstrb     <= r.strb;
    tkeep     <= r.keep;
    tlast     <= (r.last != 0);
    tid       <= r.id[`AXIS_ID_WIDTH-1:0];
    tdest     <= r.dest[`AXIS_DEST_WIDTH-1:0];
    tdata     <= cur_data;
    tuser     <= cur_user;
    eos       <= (r.eos != 0);
    log_clear <= (r.clr != 0);
  endtask

  initial
  begin : stimulus
    row_t pend_row;
    int   pend_rep;
    bit   pending;
    pending      = 1'b0;
    pend_rep     = 0;
    lfsr_state   = LFSR_SEED;
    cur_data     = '0;
    cur_user     = '0;
    prev_stalled = 1'b0;
    rst       <= 1'b1;
    tdata     <= '0;
    tstrb     <= '0;
    tkeep     <= '0;
    tlast     <= 1'b0;
    tid       <= '0;
    tdest     <= '0;
    tuser     <= '0;
    tvalid    <= 1'b0;
    tready    <= 1'b0;
    eos       <= 1'b0;
    log_clear <= 1'b0;
    build_table();
    repeat (RESET_CYCLES) @(posedge aclk);
    rst <= 1'b0;
    wait_log_idle(RESET_CYCLES);
    // Outputs at each falling edge reflect the row driven one cycle earlier
    for (int i = 0; i < rows.size(); i++)
      for (int j = 0; j < rows[i].reps; j++)
      begin
        @(posedge aclk);
        drive_inputs(rows[i]);
        @(negedge aclk);
        if (pending)
          check_outputs(pend_row, pend_rep);
        pending  = 1'b1;
        pend_row = rows[i];
        pend_rep = j;
      end
    @(posedge aclk);
    @(negedge aclk);
    check_outputs(pend_row, pend_rep);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+.
axis_mon_pkg.sv
axis_handshake_rules.sv
axis_stall_watchdog.sv
axis_stream_tracker.sv
axis_violation_log.sv
axis_protocol_monitor.sv
tb_axis_protocol_monitor.sv
